// ==== soc_bus_pkg.sv ====
/*
 * Shared types and address map for the CPU data bus.
 * Byte address is 16 bits. Bits 15:12 pick the region and bits 1:0 are ignored.
 * Region 0 is the RAM, regions 1 to 14 hold register banks and region 15 is always unmapped.
 */
`default_nettype none

package soc_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] addr_t;

    // All strobes low marks a read
    typedef logic [3:0] strb_t;

    // Held stable by the CPU until the ready pulse
    typedef struct packed {
        logic  valid;
        strb_t wstrb;
        addr_t address;
        word_t write_data;
    } bus_req_t;

    // Regions 1 to 14 are free for banks
    localparam int MAX_BANKS = 14;

    localparam logic [3:0] RAM_REGION = 4'd0;

    // Bank i decodes at region BANK_REGION_BASE + i
    localparam logic [3:0] BANK_REGION_BASE = 4'd1;

endpackage

`default_nettype wire

// ==== address_decoder.sv ====
/*
 * Turns a CPU request into one-hot slot strobes.
 * Strobes only fire on a fresh request, i.e. valid high while mem_ready is low,
 * so a request held through its ready cycle is not issued twice.
 * Any region without a slot goes to unmapped_strobe.
 */
`default_nettype none

module address_decoder #(
    parameter int NUM_BANKS = 4
) (
    input  soc_bus_pkg::bus_req_t req,
    input  logic                  mem_ready,
    output logic                  ram_strobe,
    output logic [NUM_BANKS-1:0]  bank_strobe,
    output logic                  unmapped_strobe
);

    logic                 fresh;
    logic [3:0]           region;
    logic                 ram_hit;
    logic [NUM_BANKS-1:0] bank_hit;

    assign fresh  = req.valid && !mem_ready;
    assign region = req.address[15:12];

    assign ram_hit = (region == soc_bus_pkg::RAM_REGION);

    // One comparator per bank region
    genvar i;
    generate
        for (i = 0; i < NUM_BANKS; i++) begin : g_bank_hit
            assign bank_hit[i] = (region == 4'(soc_bus_pkg::BANK_REGION_BASE + i));
        end
    endgenerate

    assign ram_strobe  = fresh && ram_hit;
    assign bank_strobe = fresh ? bank_hit : '0;

    // Nothing matched, still completes with a ready pulse
    assign unmapped_strobe = fresh && !ram_hit && !(|bank_hit);

endmodule

`default_nettype wire

// ==== cpu_ram.sv ====
/*
 * Word-wide single-port RAM with byte write strobes and a registered read.
 * Read returns the old word on a write cycle. Contents are not reset.
 * RAM_ADDR_BITS must not exceed 10, so the index stays inside the 4 KiB region.
 */
`default_nettype none

module cpu_ram #(
    parameter int RAM_ADDR_BITS = 8
) (
    input  logic                  clk,
    input  logic                  strobe,
    input  soc_bus_pkg::bus_req_t req,
    output soc_bus_pkg::word_t    read_data
);

    localparam int DEPTH = 2 ** RAM_ADDR_BITS;

    soc_bus_pkg::word_t mem [DEPTH];

    logic [RAM_ADDR_BITS-1:0] index;

    // Word index, wraps inside the region
    assign index = req.address[RAM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (strobe) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) begin
                    mem[index][b*8 +: 8] <= req.write_data[b*8 +: 8];
                end
            end
            read_data <= mem[index];
        end
    end

endmodule

`default_nettype wire

// ==== reg_bank.sv ====
/*
 * Small flip-flop register file used as a scratch and control peripheral.
 * Same access contract as cpu_ram: byte-strobed write, registered read of the old word.
 * Registers clear on reset. The offset wraps at 2**BANK_ADDR_BITS words.
 */
`default_nettype none

module reg_bank #(
    parameter int BANK_ADDR_BITS = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  strobe,
    input  soc_bus_pkg::bus_req_t req,
    output soc_bus_pkg::word_t    read_data
);

    localparam int NUM_REGS = 2 ** BANK_ADDR_BITS;

    soc_bus_pkg::word_t regs [NUM_REGS];

    logic [BANK_ADDR_BITS-1:0] index;

    // Low word-address bits only
    assign index = req.address[BANK_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (strobe) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) begin
                    regs[index][b*8 +: 8] <= req.write_data[b*8 +: 8];
                end
            end
        end
    end

    // Captured on every access, held until the next one
    always_ff @(posedge clk) begin
        if (strobe) begin
            read_data <= regs[index];
        end
    end

endmodule

`default_nettype wire

// ==== bus_arbiter.sv ====
/*
 * Completes every CPU access with a registered single-cycle ready pulse.
 * Read data is muxed combinationally from the slot strobed on the previous edge.
 * Single clock only. An unmapped access reads as zero.
 */
`default_nettype none

module bus_arbiter #(
    parameter int NUM_BANKS = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ram_strobe,
    input  logic [NUM_BANKS-1:0] bank_strobe,
    input  logic                 unmapped_strobe,
    input  soc_bus_pkg::word_t   ram_read_data,
    input  soc_bus_pkg::word_t   bank_read_data [NUM_BANKS],
    output logic                 mem_ready,
    output soc_bus_pkg::word_t   read_data
);

    logic                 any_strobe;
    logic                 ram_sel_q;
    logic [NUM_BANKS-1:0] bank_sel_q;

    assign any_strobe = ram_strobe || (|bank_strobe) || unmapped_strobe;

    // Ready follows any strobe by one edge
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= any_strobe;
        end
    end

    // Which slot answers this access, all clear when unmapped
    always_ff @(posedge clk) begin
        if (reset) begin
            ram_sel_q  <= 1'b0;
            bank_sel_q <= '0;
        end else if (any_strobe) begin
            ram_sel_q  <= ram_strobe;
            bank_sel_q <= bank_strobe;
        end
    end

    // One-hot AND-OR mux, zero by default
    always_comb begin
        read_data = '0;
        if (mem_ready) begin
            read_data = {32{ram_sel_q}} & ram_read_data;
            for (int i = 0; i < NUM_BANKS; i++) begin
                read_data = read_data | ({32{bank_sel_q[i]}} & bank_read_data[i]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== cpu_bus_top.sv ====
/*
 * CPU data-bus back end: decoder, RAM, NUM_BANKS register banks and arbiter.
 * One request outstanding. The CPU holds valid and the request until mem_ready pulses.
 * NUM_BANKS must lie in 1..MAX_BANKS. Ready comes one cycle after a fresh request.
 */
`default_nettype none

module cpu_bus_top #(
    parameter int NUM_BANKS      = 4,
    parameter int RAM_ADDR_BITS  = 8,
    parameter int BANK_ADDR_BITS = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  soc_bus_pkg::bus_req_t req,
    output logic                  mem_ready,
    output soc_bus_pkg::word_t    read_data
);

    logic                 ram_strobe;
    logic [NUM_BANKS-1:0] bank_strobe;
    logic                 unmapped_strobe;

    soc_bus_pkg::word_t ram_read_data;
    soc_bus_pkg::word_t bank_read_data [NUM_BANKS];

    // Only the free regions can hold banks
    generate
        if (NUM_BANKS < 1 || NUM_BANKS > soc_bus_pkg::MAX_BANKS) begin : g_bank_count_check
            $error("NUM_BANKS out of range 1..%0d", soc_bus_pkg::MAX_BANKS);
        end
    endgenerate

    address_decoder #(
        .NUM_BANKS(NUM_BANKS)
    ) decoder (
        .req            (req),
        .mem_ready      (mem_ready),
        .ram_strobe     (ram_strobe),
        .bank_strobe    (bank_strobe),
        .unmapped_strobe(unmapped_strobe)
    );

    cpu_ram #(
        .RAM_ADDR_BITS(RAM_ADDR_BITS)
    ) ram (
        .clk      (clk),
        .strobe   (ram_strobe),
        .req      (req),
        .read_data(ram_read_data)
    );

    genvar i;
    generate
        for (i = 0; i < NUM_BANKS; i++) begin : g_bank
            reg_bank #(
                .BANK_ADDR_BITS(BANK_ADDR_BITS)
            ) bank (
                .clk      (clk),
                .reset    (reset),
                .strobe   (bank_strobe[i]),
                .req      (req),
                .read_data(bank_read_data[i])
            );
        end
    endgenerate

    bus_arbiter #(
        .NUM_BANKS(NUM_BANKS)
    ) arbiter (
        .clk            (clk),
        .reset          (reset),
        .ram_strobe     (ram_strobe),
        .bank_strobe    (bank_strobe),
        .unmapped_strobe(unmapped_strobe),
        .ram_read_data  (ram_read_data),
        .bank_read_data (bank_read_data),
        .mem_ready      (mem_ready),
        .read_data      (read_data)
    );

endmodule

`default_nettype wire

// ==== tb_cpu_bus.sv ====
/*
 * Testbench for cpu_bus_top with its default parameters.
 * Stimulus is a table of accesses walked in order, each one issued as a single request.
 * RAM words are checked only after all four bytes have been written once.
 */
`default_nettype none

module tb_cpu_bus;

    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_BANKS      = 4;
    localparam int RAM_ADDR_BITS  = 8;
    localparam int BANK_ADDR_BITS = 3;
    localparam int RAM_WORDS      = 2 ** RAM_ADDR_BITS;
    localparam int BANK_REGS      = 2 ** BANK_ADDR_BITS;
    localparam int NUM_RANDOM     = 200;

    typedef struct packed {
        soc_bus_pkg::strb_t wstrb;
        soc_bus_pkg::addr_t address;
        soc_bus_pkg::word_t write_data;
        soc_bus_pkg::word_t expected;
        logic               check;
        logic               hold;
    } entry_t;

    logic                  clk;
    logic                  reset;
    soc_bus_pkg::bus_req_t req;
    logic                  mem_ready;
    soc_bus_pkg::word_t    read_data;

    entry_t             stimulus [$];
    soc_bus_pkg::word_t ram_shadow [RAM_WORDS];
    logic [3:0]         ram_known [RAM_WORDS];
    soc_bus_pkg::word_t bank_shadow [NUM_BANKS][BANK_REGS];
    logic [31:0]        rng_state;
    int                 current_entry;
    int                 watchdog_cycles;

    cpu_bus_top #(
        .NUM_BANKS     (NUM_BANKS),
        .RAM_ADDR_BITS (RAM_ADDR_BITS),
        .BANK_ADDR_BITS(BANK_ADDR_BITS)
    ) UUT (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .mem_ready(mem_ready),
        .read_data(read_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run;
        $display("tests failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_word(input string name, input soc_bus_pkg::word_t actual,
                              input soc_bus_pkg::word_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s entry %0d: got %h, expected %h",
                     name, current_entry, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_ready(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s entry %0d: got %h, expected %h",
                     name, current_entry, actual, expected);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Strobed bytes take the new data, the rest keep the old word
    function automatic soc_bus_pkg::word_t merge_bytes(input soc_bus_pkg::word_t old_word,
                                                       input soc_bus_pkg::word_t new_word,
                                                       input soc_bus_pkg::strb_t strb);
        soc_bus_pkg::word_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // Expected read word is the old contents, then the shadow takes the write
    task automatic add_access(input soc_bus_pkg::strb_t wstrb, input soc_bus_pkg::addr_t address,
                              input soc_bus_pkg::word_t write_data, input logic hold);
        entry_t e;
        int     ram_idx;
        int     reg_idx;
        int     bank;
        ram_idx = int'(address[RAM_ADDR_BITS+1:2]);
        reg_idx = int'(address[BANK_ADDR_BITS+1:2]);
        bank = int'(address[15:12]) - int'(soc_bus_pkg::BANK_REGION_BASE);
        e.wstrb = wstrb;
        e.address = address;
        e.write_data = write_data;
        e.hold = hold;
        if (address[15:12] == soc_bus_pkg::RAM_REGION) begin
            e.expected = ram_shadow[ram_idx];
            e.check = (ram_known[ram_idx] == 4'hF);
            ram_shadow[ram_idx] = merge_bytes(ram_shadow[ram_idx], write_data, wstrb);
            ram_known[ram_idx] = ram_known[ram_idx] | wstrb;
        end else if (bank >= 0 && bank < NUM_BANKS) begin
            e.expected = bank_shadow[bank][reg_idx];
            e.check = 1'b1;
            bank_shadow[bank][reg_idx] = merge_bytes(bank_shadow[bank][reg_idx], write_data, wstrb);
        end else begin
            e.expected = '0;
            e.check = 1'b1;
        end
        stimulus.push_back(e);
    endtask

    // Read with a hand-derived expected word
    task automatic add_read_expect(input soc_bus_pkg::addr_t address,
                                   input soc_bus_pkg::word_t expected, input logic hold);
        entry_t e;
        e.wstrb = '0;
        e.address = address;
        e.write_data = '0;
        e.expected = expected;
        e.check = 1'b1;
        e.hold = hold;
        stimulus.push_back(e);
    endtask

    task automatic build_directed;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int r = 0; r < BANK_REGS; r++) begin
                add_read_expect({4'(soc_bus_pkg::BANK_REGION_BASE + b), 12'(r * 4)}, '0, 1'b0);
            end
        end
        add_access(4'hF, 16'h0010, 32'h1122_3344, 1'b0);
        add_access(4'h0, 16'h0010, '0, 1'b1);
        add_access(4'b0101, 16'h0010, 32'hAABB_CCDD, 1'b0);
        add_read_expect(16'h0010, 32'h11BB_33DD, 1'b0);
        add_access(4'hF, 16'h0020, 32'hCAFE_F00D, 1'b1);
        add_access(4'b0010, 16'h0020, 32'h0000_7700, 1'b0);
        // Bits 11:10 sit above the RAM index
        add_read_expect(16'h0C20, 32'hCAFE_770D, 1'b0);
        add_access(4'hF, 16'h1008, 32'hB0B0_0002, 1'b0);
        add_access(4'hF, 16'h4008, 32'h3333_0002, 1'b1);
        add_read_expect(16'h1008, 32'hB0B0_0002, 1'b0);
        add_read_expect(16'h4008, 32'h3333_0002, 1'b0);
        // Offset 10 wraps to 2
        add_read_expect(16'h4028, 32'h3333_0002, 1'b0);
        add_access(4'b1100, 16'h1048, 32'h5A5A_0000, 1'b0);
        add_read_expect(16'h1008, 32'h5A5A_0002, 1'b0);
        // Region 9 has no slot
        add_read_expect(16'h9000, '0, 1'b0);
        add_access(4'hF, 16'h9010, 32'hDEAD_BEEF, 1'b1);
        add_read_expect(16'h9010, '0, 1'b0);
        add_read_expect(16'h0010, 32'h11BB_33DD, 1'b0);
        add_read_expect(16'h1010, '0, 1'b0);
        add_read_expect(16'h4008, 32'h3333_0002, 1'b0);
    endtask

    task automatic build_random;
        logic [31:0]        pick;
        logic [31:0]        data;
        int                 slot;
        soc_bus_pkg::addr_t address;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rng_state = xorshift32(rng_state);
            pick = rng_state;
            rng_state = xorshift32(rng_state);
            data = rng_state;
            slot = int'(pick[7:0]) % (NUM_BANKS + 2);
            if (slot == 0) begin
                // Few RAM words so that they get reused
                address = {soc_bus_pkg::RAM_REGION, pick[19:8] & 12'hC3F};
            end else if (slot <= NUM_BANKS) begin
                address = {4'(soc_bus_pkg::BANK_REGION_BASE + slot - 1), pick[19:8]};
            end else begin
                address = {4'd9, pick[19:8]};
            end
            add_access(pick[20] ? pick[24:21] : 4'h0, address, data, pick[27:25] == 3'd0);
        end
    endtask

    // One idle cycle, the request, the ready cycle and an optional held cycle
    task automatic issue(input entry_t e);
        int wait_cycles;
        @(posedge clk);
        #1;
        check_ready("mem_ready before request", mem_ready, 1'b0);
        req.valid = 1'b1;
        req.wstrb = e.wstrb;
        req.address = e.address;
        req.write_data = e.write_data;
        wait_cycles = 0;
        do begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end while (mem_ready !== 1'b1);
        if (wait_cycles != 1) begin
            $display("Latency error in entry %0d: mem_ready came %0d cycles after valid, not 1",
                     current_entry, wait_cycles);
            abort_run();
        end
        if (e.check) begin
            check_word("read_data", read_data, e.expected);
        end
        if (e.hold) begin
            @(posedge clk);
            #1;
            check_ready("mem_ready with valid held", mem_ready, 1'b0);
        end
        req.valid = 1'b0;
    endtask

    initial begin
        wait (watchdog_cycles > 0);
        #(watchdog_cycles * CLK_PERIOD);
        $display("Watchdog expired: a bus request never completed");
        abort_run();
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        req = '0;
        current_entry = -1;
        rng_state = 32'd13779;
        for (int w = 0; w < RAM_WORDS; w++) begin
            ram_known[w] = 4'h0;
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int r = 0; r < BANK_REGS; r++) begin
                bank_shadow[b][r] = '0;
            end
        end
        build_directed();
        build_random();
        watchdog_cycles = stimulus.size() * 4 + RESET_CYCLES + 100;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #1;
            check_ready("mem_ready while idle", mem_ready, 1'b0);
        end
        for (int n = 0; n < stimulus.size(); n++) begin
            current_entry = n;
            issue(stimulus[n]);
        end
        @(posedge clk);
        #1;
        check_ready("mem_ready after last request", mem_ready, 1'b0);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
soc_bus_pkg.sv
address_decoder.sv
cpu_ram.sv
reg_bank.sv
bus_arbiter.sv
cpu_bus_top.sv
tb_cpu_bus.sv

// ==== Makefile ====
SIM       = verilator
TOP       = tb_cpu_bus
FILELIST  = verilog.f
BUILD_DIR = obj_dir
FLAGS     = --binary --timing --top-module $(TOP) --Mdir $(BUILD_DIR)
PASS_MSG  = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
